//--- all.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/csr_pkg.sv
hw/csr_alu.sv
hw/csr_file.sv
hw/trap_unit.sv
hw/csr_ctrl.sv
hw/csr_unit_top.sv
tb/csr_unit_checker.sv
tb/csr_unit_tb.sv

//--- hw/csr_alu.sv
// csr_alu: read-modify-write of a CSR value for csrrw, csrrs and csrrc
`timescale 1ns/100ps

module csr_alu (
  input  rv_isa_pkg::csr_op_e op,
  input  logic [31:0]         csr_rdata,
  input  logic [31:0]         src,
  input  logic                src_is_zero,
  output logic [31:0]         wr_data,
  output logic                wr_req
);

  always_comb begin
    case (op)
      rv_isa_pkg::CSR_OP_WRITE: begin
        wr_data = src;
        // csrrw always writes, even with x0
        wr_req  = 1'b1;
      end
      rv_isa_pkg::CSR_OP_SET: begin
        wr_data = csr_rdata | src;
        wr_req  = !src_is_zero;
      end
      rv_isa_pkg::CSR_OP_CLEAR: begin
        wr_data = csr_rdata & ~src;
        wr_req  = !src_is_zero;
      end
      default: begin
        // keep the old value
        wr_data = csr_rdata;
        wr_req  = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/csr_cfg.svh
// csr configuration: reset values of the machine CSRs and the mtvec base alignment
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// mstatus out of reset
// MPP = 2'b11 (bits 12:11), MPIE = 1 (bit 7), MIE = 1 (bit 3)
`define CSR_RESET_MSTATUS 32'h0000_1888

// trap vector base, direct mode
`define CSR_RESET_MTVEC 32'h0000_0000

// scratch register preset, points at the machine-mode stack area
`define CSR_RESET_MSCRATCH 32'h0802_0000

// mtvec base is word aligned
// low two bits hold the vector mode and never reach the redirect pc
`define CSR_MTVEC_BASE_MASK 32'hFFFF_FFFC

`endif

//--- hw/csr_ctrl.sv
// csr_ctrl: req/ack handshake FSM, SYSTEM decode, write and trap sequencing
`timescale 1ns/100ps

module csr_ctrl (
  input  logic                    clk,
  input  logic                    reset_x,
  input  logic                    req,
  input  rv_isa_pkg::insn_u       insn,
  input  logic [31:0]             rs1_data,
  input  logic [31:0]             pc,
  input  logic [31:0]             csr_rdata,
  input  logic                    wr_req,
  input  logic [31:0]             redirect_pc_in,
  input  logic                    csr_valid,
  output logic                    ack,
  output logic [11:0]             csr_addr,
  output rv_isa_pkg::csr_op_e     op,
  output logic [31:0]             src,
  output logic                    src_is_zero,
  output csr_pkg::trap_kind_e     trap_kind,
  output logic [3:0]              cause,
  output logic                    wr_en,
  output logic [31:0]             rd_data,
  output logic                    trap,
  output logic [31:0]             redirect_pc
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_EXEC = 2'd1;
  localparam logic [1:0] ST_ACK  = 2'd2;

  logic [1:0]          state;
  logic                exec;
  logic                is_csr;
  logic                is_priv;
  logic                is_ecall;
  logic                is_ebreak;
  logic                is_mret;
  logic                illegal;
  csr_pkg::trap_kind_e kind;

  assign exec     = (state == ST_EXEC);
  assign csr_addr = insn.csr_fmt.csr;

  // funct3 picks the operation and the source
  always_comb begin
    is_csr  = 1'b0;
    is_priv = 1'b0;
    op      = rv_isa_pkg::CSR_OP_WRITE;
    case (insn.csr_fmt.funct3)
      rv_isa_pkg::F3_PRIV: is_priv = 1'b1;
      rv_isa_pkg::F3_CSRRW, rv_isa_pkg::F3_CSRRWI: begin
        is_csr = 1'b1;
        op     = rv_isa_pkg::CSR_OP_WRITE;
      end
      rv_isa_pkg::F3_CSRRS, rv_isa_pkg::F3_CSRRSI: begin
        is_csr = 1'b1;
        op     = rv_isa_pkg::CSR_OP_SET;
      end
      rv_isa_pkg::F3_CSRRC, rv_isa_pkg::F3_CSRRCI: begin
        is_csr = 1'b1;
        op     = rv_isa_pkg::CSR_OP_CLEAR;
      end
      default: ;
    endcase
  end

  // funct3[2] marks the uimm forms
  assign src = insn.csr_fmt.funct3[2] ? {27'd0, insn.csr_fmt.rs1} : rs1_data;
  // set/clear with x0 or uimm 0 must not write
  assign src_is_zero = (insn.csr_fmt.rs1 == 5'd0);

  // priv encodings need rs1 = rd = 0
  assign is_ecall  = (insn.priv_fmt.funct7 == 7'd0) &&
                     (insn.priv_fmt.rs2 == rv_isa_pkg::RS2_ECALL) &&
                     (insn.priv_fmt.rs1 == 5'd0) && (insn.priv_fmt.rd == 5'd0);
  assign is_ebreak = (insn.priv_fmt.funct7 == 7'd0) &&
                     (insn.priv_fmt.rs2 == rv_isa_pkg::RS2_EBREAK) &&
                     (insn.priv_fmt.rs1 == 5'd0) && (insn.priv_fmt.rd == 5'd0);
  assign is_mret   = (insn.priv_fmt.funct7 == rv_isa_pkg::F7_MRET) &&
                     (insn.priv_fmt.rs2 == rv_isa_pkg::RS2_MRET) &&
                     (insn.priv_fmt.rs1 == 5'd0) && (insn.priv_fmt.rd == 5'd0);

  // top two address bits both set means read-only space
  assign illegal = (insn.csr_fmt.opcode != rv_isa_pkg::OPC_SYSTEM) ||
                   (!is_csr && !is_priv) ||
                   (is_priv && !(is_ecall || is_ebreak || is_mret)) ||
                   (is_csr && !csr_valid) ||
                   (is_csr && wr_req && (csr_addr[11:10] == 2'b11));

  always_comb begin
    kind  = csr_pkg::TRAP_NONE;
    cause = csr_pkg::CAUSE_ILLEGAL;
    if (illegal) begin
      kind = csr_pkg::TRAP_EXC;
    end else if (is_priv && is_ecall) begin
      kind  = csr_pkg::TRAP_EXC;
      cause = csr_pkg::CAUSE_ECALL_M;
    end else if (is_priv && is_ebreak) begin
      kind  = csr_pkg::TRAP_EXC;
      cause = csr_pkg::CAUSE_BREAKPOINT;
    end else if (is_priv && is_mret) begin
      kind = csr_pkg::TRAP_MRET;
    end
  end

  // datapath only acts in the exec cycle
  assign trap_kind = exec ? kind : csr_pkg::TRAP_NONE;
  assign wr_en     = exec && is_csr && !illegal && wr_req;

  always_ff @(posedge clk) begin
    if (!reset_x) begin
      state       <= ST_IDLE;
      ack         <= 1'b0;
      rd_data     <= 32'd0;
      trap        <= 1'b0;
      redirect_pc <= 32'd0;
    end else begin
      case (state)
        ST_IDLE: if (req) state <= ST_EXEC;
        ST_EXEC: begin
          state       <= ST_ACK;
          ack         <= 1'b1;
          // capture strobe, held until req drops
          rd_data     <= (is_csr && !illegal) ? csr_rdata : 32'd0;
          trap        <= (kind == csr_pkg::TRAP_EXC);
          redirect_pc <= (kind == csr_pkg::TRAP_NONE) ? pc + 32'd4 : redirect_pc_in;
        end
        ST_ACK: begin
          if (!req) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
            // trap flag goes down with ack
            trap  <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- hw/csr_file.sv
// csr_file: machine CSR storage with decoded read, software write, trap entry and mret
`timescale 1ns/100ps
`include "csr_cfg.svh"

module csr_file (
  input  logic                clk,
  input  logic                reset_x,
  input  logic [11:0]         csr_addr,
  input  logic                wr_en,
  input  logic [31:0]         wr_data,
  input  csr_pkg::trap_kind_e trap_kind,
  input  logic [31:0]         mepc_in,
  input  logic [3:0]          mcause_in,
  input  logic [31:0]         mtval_in,
  output logic [31:0]         csr_rdata,
  output logic                csr_valid,
  output logic [31:0]         mtvec,
  output logic [31:0]         mepc
);

  logic [31:0] mstatus;
  logic [31:0] mie;
  logic [31:0] mscratch;
  logic [31:0] mcause;
  logic [31:0] mtval;
  logic [31:0] mip;

  // combinational read, unknown addresses flagged through csr_valid
  always_comb begin
    csr_valid = 1'b1;
    case (csr_addr)
      csr_pkg::CSR_MSTATUS:  csr_rdata = mstatus;
      csr_pkg::CSR_MIE:      csr_rdata = mie;
      csr_pkg::CSR_MTVEC:    csr_rdata = mtvec;
      csr_pkg::CSR_MSCRATCH: csr_rdata = mscratch;
      csr_pkg::CSR_MEPC:     csr_rdata = mepc;
      csr_pkg::CSR_MCAUSE:   csr_rdata = mcause;
      csr_pkg::CSR_MTVAL:    csr_rdata = mtval;
      csr_pkg::CSR_MIP:      csr_rdata = mip;
      // single hart
      csr_pkg::CSR_MHARTID:  csr_rdata = 32'd0;
      default: begin
        csr_rdata = 32'd0;
        csr_valid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_x) begin
      mstatus  <= `CSR_RESET_MSTATUS;
      mie      <= 32'd0;
      mtvec    <= `CSR_RESET_MTVEC;
      mscratch <= `CSR_RESET_MSCRATCH;
      mepc     <= 32'd0;
      mcause   <= 32'd0;
      mtval    <= 32'd0;
      mip      <= 32'd0;
    end else if (trap_kind == csr_pkg::TRAP_EXC) begin
      mepc   <= mepc_in;
      mcause <= {28'd0, mcause_in};
      mtval  <= mtval_in;
      // stack the interrupt enable
      mstatus[csr_pkg::MSTATUS_MPIE] <= mstatus[csr_pkg::MSTATUS_MIE];
      mstatus[csr_pkg::MSTATUS_MIE]  <= 1'b0;
    end else if (trap_kind == csr_pkg::TRAP_MRET) begin
      mstatus[csr_pkg::MSTATUS_MIE]  <= mstatus[csr_pkg::MSTATUS_MPIE];
      mstatus[csr_pkg::MSTATUS_MPIE] <= 1'b1;
    end else if (wr_en) begin
      case (csr_addr)
        csr_pkg::CSR_MSTATUS:  mstatus  <= wr_data;
        csr_pkg::CSR_MIE:      mie      <= wr_data;
        csr_pkg::CSR_MTVEC:    mtvec    <= wr_data;
        csr_pkg::CSR_MSCRATCH: mscratch <= wr_data;
        csr_pkg::CSR_MEPC:     mepc     <= wr_data;
        csr_pkg::CSR_MCAUSE:   mcause   <= wr_data;
        csr_pkg::CSR_MTVAL:    mtval    <= wr_data;
        // mip is plain storage, no interrupt sources
        csr_pkg::CSR_MIP:      mip      <= wr_data;
        default: ;
      endcase
    end
  end

endmodule

//--- hw/csr_pkg.sv
// csr_pkg: machine CSR addresses, mcause codes, mstatus bits and trap kinds
package csr_pkg;

  // machine trap setup
  localparam logic [11:0] CSR_MSTATUS  = 12'h300;
  localparam logic [11:0] CSR_MIE      = 12'h304;
  localparam logic [11:0] CSR_MTVEC    = 12'h305;

  // machine trap handling
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;
  localparam logic [11:0] CSR_MTVAL    = 12'h343;
  localparam logic [11:0] CSR_MIP      = 12'h344;

  // machine information, read only
  localparam logic [11:0] CSR_MHARTID  = 12'hF14;

  // mstatus bit positions
  localparam int unsigned MSTATUS_MIE  = 3;
  localparam int unsigned MSTATUS_MPIE = 7;

  // synchronous exception codes, interrupt bit always 0 here
  localparam logic [3:0] CAUSE_ILLEGAL    = 4'd2;
  localparam logic [3:0] CAUSE_BREAKPOINT = 4'd3;
  localparam logic [3:0] CAUSE_ECALL_M    = 4'd11;

  // what the trap datapath does on the exec edge
  typedef enum logic [1:0] {
    TRAP_NONE = 2'd0,
    TRAP_EXC  = 2'd1,
    TRAP_MRET = 2'd2
  } trap_kind_e;

endpackage

//--- hw/csr_unit_top.sv
// csr_unit_top: machine-mode CSR and trap unit behind a four-phase req/ack handshake
`timescale 1ns/100ps

module csr_unit_top (
  input  logic        clk,
  input  logic        reset_x,
  input  logic        req,
  input  logic [31:0] insn,
  input  logic [31:0] rs1_data,
  input  logic [31:0] pc,
  output logic        ack,
  output logic [31:0] rd_data,
  output logic        trap,
  output logic [31:0] redirect_pc
);

  logic [11:0]         csr_addr;
  rv_isa_pkg::csr_op_e op;
  logic [31:0]         src;
  logic                src_is_zero;
  csr_pkg::trap_kind_e trap_kind;
  logic [3:0]          cause;
  logic                wr_en;
  logic                wr_req;
  logic [31:0]         wr_data;
  logic [31:0]         csr_rdata;
  logic                csr_valid;
  logic [31:0]         mtvec;
  logic [31:0]         mepc;
  logic [31:0]         mepc_in;
  logic [3:0]          mcause_in;
  logic [31:0]         mtval_in;
  logic [31:0]         trap_target;

  csr_ctrl u_ctrl (
    .clk            (clk),
    .reset_x        (reset_x),
    .req            (req),
    .insn           (insn),
    .rs1_data       (rs1_data),
    .pc             (pc),
    .csr_rdata      (csr_rdata),
    .wr_req         (wr_req),
    .redirect_pc_in (trap_target),
    .csr_valid      (csr_valid),
    .ack            (ack),
    .csr_addr       (csr_addr),
    .op             (op),
    .src            (src),
    .src_is_zero    (src_is_zero),
    .trap_kind      (trap_kind),
    .cause          (cause),
    .wr_en          (wr_en),
    .rd_data        (rd_data),
    .trap           (trap),
    .redirect_pc    (redirect_pc)
  );

  csr_alu u_alu (
    .op          (op),
    .csr_rdata   (csr_rdata),
    .src         (src),
    .src_is_zero (src_is_zero),
    .wr_data     (wr_data),
    .wr_req      (wr_req)
  );

  csr_file u_file (
    .clk       (clk),
    .reset_x   (reset_x),
    .csr_addr  (csr_addr),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .trap_kind (trap_kind),
    .mepc_in   (mepc_in),
    .mcause_in (mcause_in),
    .mtval_in  (mtval_in),
    .csr_rdata (csr_rdata),
    .csr_valid (csr_valid),
    .mtvec     (mtvec),
    .mepc      (mepc)
  );

  trap_unit u_trap (
    .trap_kind   (trap_kind),
    .cause       (cause),
    .pc          (pc),
    .insn        (insn),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .mepc_in     (mepc_in),
    .mcause_in   (mcause_in),
    .mtval_in    (mtval_in),
    .redirect_pc (trap_target)
  );

endmodule

//--- hw/rv_isa_pkg.sv
// rv_isa_pkg: RV32 SYSTEM instruction formats, opcode and funct3 codes
package rv_isa_pkg;

  // csr access view: csrrw/csrrs/csrrc and immediate forms
  typedef struct packed {
    logic [11:0] csr;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } csr_fmt_t;

  // R-type view, used for ecall, ebreak and mret
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } priv_fmt_t;

  // one instruction word, decoded both ways
  typedef union packed {
    csr_fmt_t  csr_fmt;
    priv_fmt_t priv_fmt;
  } insn_u;

  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  localparam logic [2:0] F3_PRIV   = 3'b000;
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // priv encodings live in funct7 / rs2
  localparam logic [6:0] F7_MRET    = 7'b001_1000;
  localparam logic [4:0] RS2_ECALL  = 5'd0;
  localparam logic [4:0] RS2_EBREAK = 5'd1;
  localparam logic [4:0] RS2_MRET   = 5'd2;

  // read-modify-write operation
  typedef enum logic [1:0] {
    CSR_OP_WRITE = 2'd0,
    CSR_OP_SET   = 2'd1,
    CSR_OP_CLEAR = 2'd2
  } csr_op_e;

endpackage

//--- hw/trap_unit.sv
// trap_unit: trap cause, trap value and redirect target for exceptions and mret
`timescale 1ns/100ps
`include "csr_cfg.svh"

module trap_unit (
  input  csr_pkg::trap_kind_e trap_kind,
  input  logic [3:0]          cause,
  input  logic [31:0]         pc,
  input  logic [31:0]         insn,
  input  logic [31:0]         mtvec,
  input  logic [31:0]         mepc,
  output logic [31:0]         mepc_in,
  output logic [3:0]          mcause_in,
  output logic [31:0]         mtval_in,
  output logic [31:0]         redirect_pc
);

  // faulting instruction's own pc
  assign mepc_in   = pc;
  assign mcause_in = cause;

  always_comb begin
    case (cause)
      csr_pkg::CAUSE_ILLEGAL:    mtval_in = insn;
      csr_pkg::CAUSE_BREAKPOINT: mtval_in = pc;
      default:                   mtval_in = 32'd0;
    endcase
  end

  // direct mode only, mode bits dropped
  assign redirect_pc = (trap_kind == csr_pkg::TRAP_MRET) ? mepc :
                       (mtvec & `CSR_MTVEC_BASE_MASK);

endmodule

//--- tb/csr_unit_checker.sv
// csr_unit_checker: req/ack handshake assertions bound into the CSR unit top level
`timescale 1ns/100ps

module csr_unit_checker (
  input logic clk,
  input logic reset_x,
  input logic req,
  input logic ack,
  input logic trap
);

  // failed assertion count, read by the testbench verdict
  int n_fail = 0;

  // ack comes out of reset low
  a_ack_reset: assert property (@(posedge clk) !reset_x |=> !ack)
    else begin
      $error("ack high after a reset cycle");
      n_fail++;
    end

  // ack only answers a pending request
  a_ack_rise: assert property (@(posedge clk) disable iff (!reset_x)
    $rose(ack) |-> req)
    else begin
      $error("ack rose without req");
      n_fail++;
    end

  // ack drops only after req was seen low
  a_ack_fall: assert property (@(posedge clk) disable iff (!reset_x)
    $fell(ack) |-> !$past(req))
    else begin
      $error("ack fell while req was still high");
      n_fail++;
    end

  // trap belongs to the response and is never up without ack
  a_trap_ack: assert property (@(posedge clk) disable iff (!reset_x)
    trap |-> ack)
    else begin
      $error("trap high while ack is low");
      n_fail++;
    end

endmodule

bind csr_unit_top csr_unit_checker u_checker (
  .clk     (clk),
  .reset_x (reset_x),
  .req     (req),
  .ack     (ack),
  .trap    (trap)
);

//--- tb/csr_unit_tb.sv
// csr_unit_tb: table-driven testbench for the CSR and trap unit over its req/ack handshake
`timescale 1ns/100ps

module csr_unit_tb;

  localparam int N_TESTS = 34;
  localparam logic [2:0] F3_RW  = 3'b001;
  localparam logic [2:0] F3_RS  = 3'b010;
  localparam logic [2:0] F3_RC  = 3'b011;
  localparam logic [2:0] F3_RSV = 3'b100;
  localparam logic [2:0] F3_RWI = 3'b101;
  localparam logic [2:0] F3_RSI = 3'b110;
  localparam logic [2:0] F3_RCI = 3'b111;
  localparam logic [31:0] ECALL  = 32'h0000_0073;
  localparam logic [31:0] EBREAK = 32'h0010_0073;
  localparam logic [31:0] MRET   = 32'h3020_0073;
  // mtvec is written as 0x2003, mode bits dropped
  localparam logic [31:0] VEC    = 32'h0000_2000;

  logic        clk;
  logic        reset_x;
  logic        req;
  logic [31:0] insn;
  logic [31:0] rs1_data;
  logic [31:0] pc;
  logic        ack;
  logic [31:0] rd_data;
  logic        trap;
  logic [31:0] redirect_pc;

  logic [31:0] tbl_insn  [N_TESTS];
  logic [31:0] tbl_rs1   [N_TESTS];
  logic [31:0] tbl_pc    [N_TESTS];
  logic [31:0] tbl_rd    [N_TESTS];
  logic [31:0] tbl_redir [N_TESTS];
  logic        tbl_trap  [N_TESTS];
  int          n_tbl;
  int          errors;
  int          failed;
  logic [31:0] lfsr;

  csr_unit_top dut0 (
    .clk         (clk),
    .reset_x     (reset_x),
    .req         (req),
    .insn        (insn),
    .rs1_data    (rs1_data),
    .pc          (pc),
    .ack         (ack),
    .rd_data     (rd_data),
    .trap        (trap),
    .redirect_pc (redirect_pc)
  );

  always #5 clk = ~clk;

  // csr access word, rd is always x1
  function automatic logic [31:0] encode_csr(input logic [11:0] addr, input logic [4:0] rs1,
                                             input logic [2:0] f3);
    return {addr, rs1, f3, 5'd1, 7'h73};
  endfunction

  function automatic logic [31:0] entry_pc(input int idx);
    return 32'h0000_1000 + 4 * idx;
  endfunction

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic add_seq(input logic [31:0] i, input logic [31:0] r, input logic [31:0] exp_rd);
    tbl_insn[n_tbl]  = i;
    tbl_rs1[n_tbl]   = r;
    tbl_pc[n_tbl]    = entry_pc(n_tbl);
    tbl_rd[n_tbl]    = exp_rd;
    tbl_trap[n_tbl]  = 1'b0;
    tbl_redir[n_tbl] = entry_pc(n_tbl) + 4;
    n_tbl++;
  endtask

  // traps and mret return no rd value
  task automatic add_trap(input logic [31:0] i, input logic [31:0] exp_redir, input logic t);
    tbl_insn[n_tbl]  = i;
    tbl_rs1[n_tbl]   = 32'd0;
    tbl_pc[n_tbl]    = entry_pc(n_tbl);
    tbl_rd[n_tbl]    = 32'd0;
    tbl_trap[n_tbl]  = t;
    tbl_redir[n_tbl] = exp_redir;
    n_tbl++;
  endtask

  task automatic build_table();
    logic [31:0] epc;
    logic [31:0] bpc;
    logic [31:0] bad;
    add_seq(encode_csr(12'h300, 5'd0, F3_RS), 32'h0, 32'h0000_1888);
    add_seq(encode_csr(12'h305, 5'd0, F3_RS), 32'h0, 32'h0000_0000);
    add_seq(encode_csr(12'h340, 5'd0, F3_RS), 32'h0, 32'h0802_0000);
    add_seq(encode_csr(12'h340, 5'd5, F3_RW), 32'hA5A5_0F0F, 32'h0802_0000);
    add_seq(encode_csr(12'h340, 5'd6, F3_RS), 32'h0000_F0F0, 32'hA5A5_0F0F);
    add_seq(encode_csr(12'h340, 5'd7, F3_RC), 32'hA500_000F, 32'hA5A5_FFFF);
    // x0 source, the data must be ignored
    add_seq(encode_csr(12'h340, 5'd0, F3_RS), 32'hFFFF_FFFF, 32'h00A5_FFF0);
    add_seq(encode_csr(12'h340, 5'd0, F3_RS), 32'h0, 32'h00A5_FFF0);
    add_seq(encode_csr(12'h304, 5'h15, F3_RWI), 32'hDEAD_BEEF, 32'h0000_0000);
    add_seq(encode_csr(12'h304, 5'h0A, F3_RSI), 32'h0, 32'h0000_0015);
    add_seq(encode_csr(12'h304, 5'h03, F3_RCI), 32'h0, 32'h0000_001F);
    add_seq(encode_csr(12'h304, 5'h00, F3_RSI), 32'h0, 32'h0000_001C);
    add_seq(encode_csr(12'h305, 5'd8, F3_RW), 32'h0000_2003, 32'h0000_0000);
    epc = entry_pc(n_tbl);
    add_trap(ECALL, VEC, 1'b1);
    add_seq(encode_csr(12'h342, 5'd0, F3_RS), 32'h0, 32'd11);
    add_seq(encode_csr(12'h341, 5'd0, F3_RS), 32'h0, epc);
    add_seq(encode_csr(12'h300, 5'd0, F3_RS), 32'h0, 32'h0000_1880);
    bpc = entry_pc(n_tbl);
    add_trap(EBREAK, VEC, 1'b1);
    add_seq(encode_csr(12'h342, 5'd0, F3_RS), 32'h0, 32'd3);
    add_seq(encode_csr(12'h343, 5'd0, F3_RS), 32'h0, bpc);
    // set MPIE again before mret
    add_seq(encode_csr(12'h300, 5'd9, F3_RS), 32'h0000_0080, 32'h0000_1800);
    add_seq(encode_csr(12'h341, 5'd10, F3_RW), 32'h0000_3000, bpc);
    add_trap(MRET, 32'h0000_3000, 1'b0);
    add_seq(encode_csr(12'h300, 5'd0, F3_RS), 32'h0, 32'h0000_1888);
    bad = encode_csr(12'h7C0, 5'd0, F3_RS);
    add_trap(bad, VEC, 1'b1);
    add_seq(encode_csr(12'h342, 5'd0, F3_RS), 32'h0, 32'd2);
    add_seq(encode_csr(12'h343, 5'd0, F3_RS), 32'h0, bad);
    bad = encode_csr(12'hF14, 5'd1, F3_RW);
    add_trap(bad, VEC, 1'b1);
    add_seq(encode_csr(12'h342, 5'd0, F3_RS), 32'h0, 32'd2);
    add_seq(encode_csr(12'h343, 5'd0, F3_RS), 32'h0, bad);
    bad = encode_csr(12'h340, 5'd0, F3_RSV);
    add_trap(bad, VEC, 1'b1);
    add_seq(encode_csr(12'h342, 5'd0, F3_RS), 32'h0, 32'd2);
    add_seq(encode_csr(12'h343, 5'd0, F3_RS), 32'h0, bad);
    add_seq(encode_csr(12'hF14, 5'd0, F3_RS), 32'h0, 32'h0000_0000);
  endtask

  task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error: %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic run_test(input int idx);
    logic [31:0] held_rd;
    logic [31:0] held_redir;
    logic        held_trap;
    int          hold;
    int          cnt;
    int          b;
    int          errs_before;
    errs_before = errors;
    hold = 0;
    for (b = 0; b < 3; b++) begin
      hold = {hold[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    assert (!ack) else begin
      $display("new request would start while ack is still high in test %0d", idx);
      errors++;
    end
    @(posedge clk);
    req      <= 1'b1;
    insn     <= tbl_insn[idx];
    rs1_data <= tbl_rs1[idx];
    pc       <= tbl_pc[idx];
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!ack && cnt < 8);
    if (!ack) begin
      $display("no ack within 8 cycles in test %0d", idx);
      errors++;
    end else begin
      // req sampled on the next edge, ack registered one edge later
      compare_word("ack latency", cnt, 3);
      compare_word("rd_data", rd_data, tbl_rd[idx]);
      compare_word("trap", {31'd0, trap}, {31'd0, tbl_trap[idx]});
      compare_word("redirect_pc", redirect_pc, tbl_redir[idx]);
    end
    held_rd    = rd_data;
    held_trap  = trap;
    held_redir = redirect_pc;
    repeat (hold) begin
      @(negedge clk);
      compare_word("ack", {31'd0, ack}, 32'd1);
      compare_word("rd_data", rd_data, held_rd);
      compare_word("trap", {31'd0, trap}, {31'd0, held_trap});
      compare_word("redirect_pc", redirect_pc, held_redir);
    end
    @(posedge clk);
    req <= 1'b0;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (ack && cnt < 8);
    if (ack) begin
      $display("ack did not fall within 8 cycles after req dropped in test %0d", idx);
      errors++;
    end
    if (errors != errs_before) begin
      failed++;
    end
    $display("test %2d insn %h hold %0d %s", idx, tbl_insn[idx], hold,
             (errors == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    clk      = 1'b0;
    reset_x  = 1'b0;
    req      = 1'b0;
    insn     = 32'd0;
    rs1_data = 32'd0;
    pc       = 32'd0;
    lfsr     = 32'h2421_1761;
    errors   = 0;
    failed   = 0;
    n_tbl    = 0;
    build_table();
    repeat (8) @(posedge clk);
    reset_x <= 1'b1;
    for (int i = 0; i < n_tbl; i++) begin
      run_test(i);
    end
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d", n_tbl, failed,
             errors, dut0.u_checker.n_fail);
    if (errors == 0 && dut0.u_checker.n_fail == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // 20 cycles per entry covers the longest back-pressure hold
  initial begin
    repeat (N_TESTS * 20 + 8) @(posedge clk);
    $display("timeout, the tests did not finish within %0d cycles", N_TESTS * 20 + 8);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
